/* hw/rvfi_check_defs.svh */
`ifndef RVFI_CHECK_DEFS_SVH
`define RVFI_CHECK_DEFS_SVH

// data and pc width
`define RC_XLEN 32

// spec lanes, must be a power of two
// a lane needs two cycles per record, so two lanes keep up with one record per cycle
`define RC_NUM_LANES 2

// error counter width, saturates at all ones
`define RC_CNT_W 16

`endif

/* hw/rvfi_check_pkg.sv */
`include "rvfi_check_defs.svh"

package rvfi_check_pkg;

  typedef logic [`RC_XLEN-1:0] xlen_t;                   // data or pc value
  typedef logic [31:0] insn_t;                           // instruction word
  typedef logic [4:0] reg_addr_t;                        // register address
  typedef logic [$clog2(`RC_NUM_LANES)-1:0] lane_id_t;  // lane index
  typedef logic [`RC_CNT_W-1:0] err_count_t;            // failure count

  // check outcome, one per retired record
  typedef enum logic [2:0] {
    V_PASS    = 3'd0,
    V_SKIP    = 3'd1,  // system opcode or trapped
    V_ILLEGAL = 3'd2,  // unsupported encoding, no trap
    V_RD_ADDR = 3'd3,
    V_RD_DATA = 3'd4,
    V_PC      = 3'd5
  } verdict_e;

  // spec lane sequencing
  typedef enum logic [1:0] {
    L_IDLE = 2'd0,
    L_EVAL = 2'd1,  // decode and compute
    L_DONE = 2'd2   // verdict valid
  } lane_state_e;

endpackage

/* hw/retire_if.sv */
// one retirement record, valid for a single cycle
interface retire_if;
  import rvfi_check_pkg::*;

  logic      valid;
  insn_t     insn;
  xlen_t     pc_rdata;
  xlen_t     rs1_rdata;
  xlen_t     rs2_rdata;
  reg_addr_t rd_addr;
  xlen_t     rd_wdata;
  xlen_t     pc_wdata;
  logic      trap;

  modport src (
    output valid, insn, pc_rdata, rs1_rdata, rs2_rdata, rd_addr, rd_wdata, pc_wdata, trap
  );

  modport dst (
    input valid, insn, pc_rdata, rs1_rdata, rs2_rdata, rd_addr, rd_wdata, pc_wdata, trap
  );
endinterface

// one lane result
interface verdict_if;
  import rvfi_check_pkg::*;

  logic     valid;
  verdict_e verdict;
  xlen_t    pc;
  insn_t    insn;

  modport src (
    output valid, verdict, pc, insn
  );

  modport dst (
    input valid, verdict, pc, insn
  );
endinterface

/* hw/retire_dispatch.sv */
`include "rvfi_check_defs.svh"

module retire_dispatch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  rvfi_check_pkg::insn_t in_insn,
  input  rvfi_check_pkg::xlen_t in_pc_rdata,
  input  rvfi_check_pkg::xlen_t in_rs1_rdata,
  input  rvfi_check_pkg::xlen_t in_rs2_rdata,
  input  rvfi_check_pkg::xlen_t in_rd_wdata,
  input  rvfi_check_pkg::xlen_t in_pc_wdata,
  input  rvfi_check_pkg::reg_addr_t in_rd_addr,
  input  logic                  in_trap,
  retire_if.src                 lanes [`RC_NUM_LANES]
);
  import rvfi_check_pkg::*;

  logic      valid_q;
  lane_id_t  ptr_q;     // lane for the next record
  lane_id_t  sel_q;     // lane of the held record
  insn_t     insn_q;
  xlen_t     pc_rdata_q;
  xlen_t     rs1_rdata_q;
  xlen_t     rs2_rdata_q;
  xlen_t     rd_wdata_q;
  xlen_t     pc_wdata_q;
  reg_addr_t rd_addr_q;
  logic      trap_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      ptr_q   <= '0;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin
        ptr_q <= ptr_q + 1'b1;  // wraps, lane count is a power of two
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      sel_q       <= ptr_q;
      insn_q      <= in_insn;
      pc_rdata_q  <= in_pc_rdata;
      rs1_rdata_q <= in_rs1_rdata;
      rs2_rdata_q <= in_rs2_rdata;
      rd_wdata_q  <= in_rd_wdata;
      pc_wdata_q  <= in_pc_wdata;
      rd_addr_q   <= in_rd_addr;
      trap_q      <= in_trap;
    end
  end

  // payload fans out to every lane, only the selected one sees valid
  for (genvar i = 0; i < `RC_NUM_LANES; i++) begin : g_lane
    assign lanes[i].valid     = valid_q && (sel_q == lane_id_t'(i));
    assign lanes[i].insn      = insn_q;
    assign lanes[i].pc_rdata  = pc_rdata_q;
    assign lanes[i].rs1_rdata = rs1_rdata_q;
    assign lanes[i].rs2_rdata = rs2_rdata_q;
    assign lanes[i].rd_addr   = rd_addr_q;
    assign lanes[i].rd_wdata  = rd_wdata_q;
    assign lanes[i].pc_wdata  = pc_wdata_q;
    assign lanes[i].trap      = trap_q;
  end
endmodule

/* hw/rv32i_spec_lane.sv */
module rv32i_spec_lane (
  input logic   clk,
  input logic   rst,
  retire_if.dst rec,
  verdict_if.src res
);
  import rvfi_check_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  lane_state_e state;
  logic        accept;

  insn_t     r_insn;
  xlen_t     r_pc;
  xlen_t     r_rs1;
  xlen_t     r_rs2;
  xlen_t     r_rd_wdata;
  xlen_t     r_pc_wdata;
  reg_addr_t r_rd_addr;
  logic      r_trap;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_field;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;
  xlen_t      pc_plus4;
  xlen_t      jalr_sum;

  xlen_t alu_b;
  logic  alu_alt;
  xlen_t sra_out;
  xlen_t alu_out;
  logic  br_take;
  logic  legal;

  xlen_t     rd_val;
  reg_addr_t spec_rd_addr;
  xlen_t     spec_rd_wdata;
  xlen_t     spec_pc_wdata;
  verdict_e  verdict_d;
  verdict_e  verdict_q;

  // a new record may land while the previous verdict is still out
  assign accept = rec.valid && (state != L_EVAL);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= L_IDLE;
    end else begin
      case (state)
        L_IDLE:  state <= rec.valid ? L_EVAL : L_IDLE;
        L_EVAL:  state <= L_DONE;
        L_DONE:  state <= rec.valid ? L_EVAL : L_IDLE;
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      r_insn     <= rec.insn;
      r_pc       <= rec.pc_rdata;
      r_rs1      <= rec.rs1_rdata;
      r_rs2      <= rec.rs2_rdata;
      r_rd_wdata <= rec.rd_wdata;
      r_pc_wdata <= rec.pc_wdata;
      r_rd_addr  <= rec.rd_addr;
      r_trap     <= rec.trap;
    end
    if (state == L_EVAL) begin
      verdict_q <= verdict_d;
    end
  end

  // field extraction and immediates
  assign opcode   = r_insn[6:0];
  assign funct3   = r_insn[14:12];
  assign funct7   = r_insn[31:25];
  assign rd_field = r_insn[11:7];
  assign imm_i    = {{20{r_insn[31]}}, r_insn[31:20]};
  assign imm_u    = {r_insn[31:12], 12'b0};
  assign imm_b    = {{19{r_insn[31]}}, r_insn[31], r_insn[7], r_insn[30:25], r_insn[11:8], 1'b0};
  assign imm_j    = {{11{r_insn[31]}}, r_insn[31], r_insn[19:12], r_insn[20], r_insn[30:21],
                     1'b0};
  assign pc_plus4 = r_pc + 32'd4;
  assign jalr_sum = r_rs1 + imm_i;

  // shared alu for op and op-imm
  assign alu_b   = (opcode == OPC_OP) ? r_rs2 : imm_i;
  assign alu_alt = (opcode == OPC_OP) ? funct7[5] : ((funct3 == 3'b101) && funct7[5]);
  assign sra_out = $signed(r_rs1) >>> alu_b[4:0];

  always_comb begin
    case (funct3)
      3'b000:  alu_out = alu_alt ? (r_rs1 - alu_b) : (r_rs1 + alu_b);
      3'b001:  alu_out = r_rs1 << alu_b[4:0];
      3'b010:  alu_out = xlen_t'($signed(r_rs1) < $signed(alu_b));
      3'b011:  alu_out = xlen_t'(r_rs1 < alu_b);
      3'b100:  alu_out = r_rs1 ^ alu_b;
      3'b101:  alu_out = alu_alt ? sra_out : (r_rs1 >> alu_b[4:0]);
      3'b110:  alu_out = r_rs1 | alu_b;
      default: alu_out = r_rs1 & alu_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  br_take = (r_rs1 == r_rs2);
      3'b001:  br_take = (r_rs1 != r_rs2);
      3'b100:  br_take = ($signed(r_rs1) < $signed(r_rs2));
      3'b101:  br_take = ($signed(r_rs1) >= $signed(r_rs2));
      3'b110:  br_take = (r_rs1 < r_rs2);
      3'b111:  br_take = (r_rs1 >= r_rs2);
      default: br_take = 1'b0;
    endcase
  end

  // supported encodings only
  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: legal = 1'b1;
      OPC_JALR:   legal = (funct3 == 3'b000);
      OPC_BRANCH: legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      OPC_OPIMM: begin
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          legal = 1'b1;  // funct7 is immediate here
        end
      end
      OPC_OP: legal = (funct7 == 7'b0000000) ||
                      ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    spec_rd_addr  = rd_field;
    spec_pc_wdata = pc_plus4;
    rd_val        = alu_out;
    case (opcode)
      OPC_LUI:   rd_val = imm_u;
      OPC_AUIPC: rd_val = r_pc + imm_u;
      OPC_JAL: begin
        rd_val        = pc_plus4;
        spec_pc_wdata = r_pc + imm_j;
      end
      OPC_JALR: begin
        rd_val        = pc_plus4;
        spec_pc_wdata = {jalr_sum[$bits(xlen_t)-1:1], 1'b0};
      end
      OPC_BRANCH: begin
        spec_rd_addr = '0;  // branches write nothing
        if (br_take) begin
          spec_pc_wdata = r_pc + imm_b;
        end
      end
      default: ;
    endcase
    spec_rd_wdata = (spec_rd_addr == '0) ? '0 : rd_val;
  end

  // verdict priority
  always_comb begin
    if (r_trap || (opcode == OPC_SYSTEM)) begin
      verdict_d = V_SKIP;
    end else if (!legal) begin
      verdict_d = V_ILLEGAL;
    end else if (r_rd_addr != spec_rd_addr) begin
      verdict_d = V_RD_ADDR;
    end else if (r_rd_wdata != spec_rd_wdata) begin
      verdict_d = V_RD_DATA;
    end else if (r_pc_wdata != spec_pc_wdata) begin
      verdict_d = V_PC;
    end else begin
      verdict_d = V_PASS;
    end
  end

  // record regs reload only after the collector has sampled
  assign res.valid   = (state == L_DONE);
  assign res.verdict = verdict_q;
  assign res.pc      = r_pc;
  assign res.insn    = r_insn;
endmodule

/* hw/verdict_collect.sv */
`include "rvfi_check_defs.svh"

module verdict_collect (
  input  logic                       clk,
  input  logic                       rst,
  verdict_if.dst                     lanes [`RC_NUM_LANES],
  output logic                       out_valid,
  output rvfi_check_pkg::verdict_e   out_verdict,
  output rvfi_check_pkg::xlen_t      out_pc,
  output rvfi_check_pkg::insn_t      out_insn,
  output rvfi_check_pkg::err_count_t error_count
);
  import rvfi_check_pkg::*;

  logic [`RC_NUM_LANES-1:0] lane_valid;
  verdict_e lane_verdict [`RC_NUM_LANES];
  xlen_t    lane_pc [`RC_NUM_LANES];
  insn_t    lane_insn [`RC_NUM_LANES];

  logic     sel_valid;
  logic     sel_fail;
  verdict_e sel_verdict;
  xlen_t    sel_pc;
  insn_t    sel_insn;

  for (genvar i = 0; i < `RC_NUM_LANES; i++) begin : g_lane
    assign lane_valid[i]   = lanes[i].valid;
    assign lane_verdict[i] = lanes[i].verdict;
    assign lane_pc[i]      = lanes[i].pc;
    assign lane_insn[i]    = lanes[i].insn;
  end

  // lanes finish in dispatch order, one at a time
  always_comb begin
    sel_verdict = V_PASS;
    sel_pc      = '0;
    sel_insn    = '0;
    for (int i = 0; i < `RC_NUM_LANES; i++) begin
      if (lane_valid[i]) begin
        sel_verdict = lane_verdict[i];
        sel_pc      = lane_pc[i];
        sel_insn    = lane_insn[i];
      end
    end
  end

  assign sel_valid = |lane_valid;
  assign sel_fail  = sel_valid && !(sel_verdict inside {V_PASS, V_SKIP});

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid   <= 1'b0;
      error_count <= '0;
    end else begin
      out_valid <= sel_valid;
      if (sel_fail && (error_count != '1)) begin
        error_count <= error_count + 1'b1;  // saturating
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      out_verdict <= sel_verdict;
      out_pc      <= sel_pc;
      out_insn    <= sel_insn;
    end
  end
endmodule

/* hw/rvfi_check_top.sv */
`include "rvfi_check_defs.svh"

module rvfi_check_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       retire_valid,
  input  rvfi_check_pkg::insn_t      retire_insn,
  input  rvfi_check_pkg::xlen_t      retire_pc_rdata,
  input  rvfi_check_pkg::xlen_t      retire_rs1_rdata,
  input  rvfi_check_pkg::xlen_t      retire_rs2_rdata,
  input  rvfi_check_pkg::xlen_t      retire_rd_wdata,
  input  rvfi_check_pkg::xlen_t      retire_pc_wdata,
  input  rvfi_check_pkg::reg_addr_t  retire_rd_addr,
  input  logic                       retire_trap,
  output logic                       chk_valid,
  output rvfi_check_pkg::verdict_e   chk_verdict,
  output rvfi_check_pkg::xlen_t      chk_pc,
  output rvfi_check_pkg::insn_t      chk_insn,
  output rvfi_check_pkg::err_count_t error_count
);

  retire_if  rec_bus [`RC_NUM_LANES] ();  // dispatcher to lanes
  verdict_if res_bus [`RC_NUM_LANES] ();  // lanes to collector

  // edge n record, n+1 on lane
  retire_dispatch u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (retire_valid),
    .in_insn      (retire_insn),
    .in_pc_rdata  (retire_pc_rdata),
    .in_rs1_rdata (retire_rs1_rdata),
    .in_rs2_rdata (retire_rs2_rdata),
    .in_rd_wdata  (retire_rd_wdata),
    .in_pc_wdata  (retire_pc_wdata),
    .in_rd_addr   (retire_rd_addr),
    .in_trap      (retire_trap),
    .lanes        (rec_bus)
  );

  // two cycles each, round-robin keeps them busy in turn
  for (genvar i = 0; i < `RC_NUM_LANES; i++) begin : g_lane
    rv32i_spec_lane u_lane (
      .clk (clk),
      .rst (rst),
      .rec (rec_bus[i]),
      .res (res_bus[i])
    );
  end

  // chk_valid sampled at n+4
  verdict_collect u_collect (
    .clk         (clk),
    .rst         (rst),
    .lanes       (res_bus),
    .out_valid   (chk_valid),
    .out_verdict (chk_verdict),
    .out_pc      (chk_pc),
    .out_insn    (chk_insn),
    .error_count (error_count)
  );
endmodule

/* bench/rvfi_check_asserts.sv */
module rvfi_check_asserts (
  input logic                       clk,
  input logic                       rst,
  input logic                       retire_valid,
  input logic                       chk_valid,
  input rvfi_check_pkg::verdict_e   chk_verdict,
  input rvfi_check_pkg::err_count_t error_count
);
  import rvfi_check_pkg::*;

  // nothing can reach the output this soon after reset
  a_quiet_after_reset: assert property (@(posedge clk)
    chk_valid |-> !($past(rst, 1) || $past(rst, 2) || $past(rst, 3) || $past(rst, 4)))
    else $error("chk_valid within four cycles of reset release");

  a_latency_fwd: assert property (@(posedge clk) disable iff (rst)
    $past(retire_valid, 4) |-> chk_valid)
    else $error("retired record without a verdict four cycles later");

  a_latency_back: assert property (@(posedge clk) disable iff (rst)
    chk_valid |-> $past(retire_valid, 4))
    else $error("verdict without a record four cycles earlier");

  // counter moves together with a failing verdict
  a_count_on_fail: assert property (@(posedge clk) disable iff (rst)
    !$stable(error_count) |-> (chk_valid && chk_verdict != V_PASS && chk_verdict != V_SKIP))
    else $error("error_count changed without a failing verdict");
endmodule

bind rvfi_check_top rvfi_check_asserts u_asserts (
  .clk          (clk),
  .rst          (rst),
  .retire_valid (retire_valid),
  .chk_valid    (chk_valid),
  .chk_verdict  (chk_verdict),
  .error_count  (error_count)
);

/* bench/rvfi_check_tb.sv */
module rvfi_check_tb;
  import rvfi_check_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int LATENCY    = 4;  // cycles from retire strobe to verdict

  logic       clk;
  logic       rst;
  logic       retire_valid;
  insn_t      retire_insn;
  xlen_t      retire_pc_rdata;
  xlen_t      retire_rs1_rdata;
  xlen_t      retire_rs2_rdata;
  xlen_t      retire_rd_wdata;
  xlen_t      retire_pc_wdata;
  reg_addr_t  retire_rd_addr;
  logic       retire_trap;
  logic       chk_valid;
  verdict_e   chk_verdict;
  xlen_t      chk_pc;
  insn_t      chk_insn;
  err_count_t error_count;

  // records as read from the vector file
  insn_t     vec_insn [$];
  xlen_t     vec_pc [$];
  xlen_t     vec_rs1 [$];
  xlen_t     vec_rs2 [$];
  reg_addr_t vec_rd_addr [$];
  xlen_t     vec_rd_wdata [$];
  xlen_t     vec_pc_wdata [$];
  logic      vec_trap [$];
  verdict_e  vec_verdict [$];
  int        exp_fails;

  // scoreboard, one entry per record in flight
  verdict_e exp_verdict_q [$];
  xlen_t    exp_pc_q [$];
  insn_t    exp_insn_q [$];
  time      exp_time_q [$];

  rvfi_check_top UUT (
    .clk              (clk),
    .rst              (rst),
    .retire_valid     (retire_valid),
    .retire_insn      (retire_insn),
    .retire_pc_rdata  (retire_pc_rdata),
    .retire_rs1_rdata (retire_rs1_rdata),
    .retire_rs2_rdata (retire_rs2_rdata),
    .retire_rd_wdata  (retire_rd_wdata),
    .retire_pc_wdata  (retire_pc_wdata),
    .retire_rd_addr   (retire_rd_addr),
    .retire_trap      (retire_trap),
    .chk_valid        (chk_valid),
    .chk_verdict      (chk_verdict),
    .chk_pc           (chk_pc),
    .chk_insn         (chk_insn),
    .error_count      (error_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("MISMATCH at %0t: %s", $time, what));
  endtask

  task automatic check_verdict(input verdict_e got, input verdict_e exp, input xlen_t pc);
    if (got !== exp) begin
      report_mismatch($sformatf("verdict %s, expected %s (pc %h)", got.name(), exp.name(), pc));
    end
  endtask

  task automatic check_xlen(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_insn(input insn_t got, input insn_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("insn %h, expected %h", got, exp));
    end
  endtask

  task automatic check_latency(input time sampled, input xlen_t pc);
    if ($time - sampled != LATENCY * CLK_PERIOD) begin
      report_mismatch($sformatf("verdict for pc %h after %0t, expected %0d cycles",
                                pc, $time - sampled, LATENCY));
    end
  endtask

  task automatic check_count(input err_count_t got, input err_count_t exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("MISMATCH at %0t: error_count %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic load_vectors();
    int        fd;
    int        n;
    int        code;
    string     line;
    insn_t     insn;
    xlen_t     pc;
    xlen_t     rs1;
    xlen_t     rs2;
    reg_addr_t rd;
    xlen_t     wd;
    xlen_t     pcw;
    logic      trap;
    fd = $fopen("bench/rvfi_check_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("could not open bench/rvfi_check_vectors.txt");
    end
    exp_fails = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;  // blank or column note
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", insn, pc, rs1, rs2, rd, wd, pcw, trap, code);
      if (n != 9) begin
        stop_run($sformatf("malformed vector line: %s", line));
      end
      vec_insn.push_back(insn);
      vec_pc.push_back(pc);
      vec_rs1.push_back(rs1);
      vec_rs2.push_back(rs2);
      vec_rd_addr.push_back(rd);
      vec_rd_wdata.push_back(wd);
      vec_pc_wdata.push_back(pcw);
      vec_trap.push_back(trap);
      vec_verdict.push_back(verdict_e'(code));
      if (verdict_e'(code) != V_PASS && verdict_e'(code) != V_SKIP) begin
        exp_fails++;  // counted by the checker
      end
    end
    $fclose(fd);
  endtask

  task automatic send_record(input int i);
    retire_valid     <= 1'b1;
    retire_insn      <= vec_insn[i];
    retire_pc_rdata  <= vec_pc[i];
    retire_rs1_rdata <= vec_rs1[i];
    retire_rs2_rdata <= vec_rs2[i];
    retire_rd_addr   <= vec_rd_addr[i];
    retire_rd_wdata  <= vec_rd_wdata[i];
    retire_pc_wdata  <= vec_pc_wdata[i];
    retire_trap      <= vec_trap[i];
    exp_verdict_q.push_back(vec_verdict[i]);
    exp_pc_q.push_back(vec_pc[i]);
    exp_insn_q.push_back(vec_insn[i]);
    exp_time_q.push_back($time + CLK_PERIOD);  // DUT samples on the next edge
  endtask

  task automatic watchdog(input int n);
    repeat (n * LATENCY + 50) @(posedge clk);
    stop_run($sformatf("timeout after %0d cycles with %0d verdicts outstanding",
                       n * LATENCY + 50, exp_verdict_q.size()));
  endtask

  always @(posedge clk) begin : monitor
    verdict_e exp_v;
    xlen_t    exp_p;
    insn_t    exp_i;
    time      t_in;
    if (!rst && chk_valid) begin
      if (exp_verdict_q.size() == 0) begin
        stop_run($sformatf("verdict for pc %h arrived with no record pending", chk_pc));
      end
      exp_v = exp_verdict_q.pop_front();
      exp_p = exp_pc_q.pop_front();
      exp_i = exp_insn_q.pop_front();
      t_in  = exp_time_q.pop_front();
      check_latency(t_in, exp_p);
      check_verdict(chk_verdict, exp_v, exp_p);
      check_xlen(chk_pc, exp_p, "pc");
      check_insn(chk_insn, exp_i);
    end
  end

  initial begin
    int gap;
    bit ok;
    clk              = 1'b0;
    rst              = 1'b1;
    retire_valid     = 1'b0;
    retire_insn      = '0;
    retire_pc_rdata  = '0;
    retire_rs1_rdata = '0;
    retire_rs2_rdata = '0;
    retire_rd_wdata  = '0;
    retire_pc_wdata  = '0;
    retire_rd_addr   = '0;
    retire_trap      = 1'b0;
    void'($urandom(32'hd67b));
    load_vectors();
    fork
      watchdog(vec_insn.size());
    join_none
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < vec_insn.size(); i++) begin
      @(posedge clk);
      send_record(i);
      // random gaps first, second half back to back
      gap = (i < vec_insn.size() / 2) ? int'($urandom % 3) : 0;
      repeat (gap) begin
        @(posedge clk);
        retire_valid <= 1'b0;
      end
    end
    @(posedge clk);
    retire_valid <= 1'b0;
    while (exp_verdict_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    check_count(error_count, err_count_t'(exp_fails), ok);
    if (ok) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "error count differs");
    end
  end
endmodule

/* bench/rvfi_check_vectors.txt */
# columns, all hex: insn pc_rdata rs1_rdata rs2_rdata rd_addr rd_wdata pc_wdata trap verdict
# verdict: 0 pass, 1 skip, 2 illegal, 3 rd addr, 4 rd data, 5 pc
00510093 00001000 00000010 00000000 01 00000015 00001004 0 0
fff08193 00001004 00000000 00000000 03 ffffffff 00001008 0 0
ffe2a213 00001008 fffffff0 00000000 04 00000001 0000100c 0 0
0ff3c313 00001010 12345678 00000000 06 12345687 00001014 0 0
00449413 00001014 000000f1 00000000 08 00000f10 00001018 0 0
4085d513 00001018 80000000 00000000 0a ff800000 0000101c 0 0
0f06f613 00001020 0000abcd 00000000 0c 000000c0 00001024 0 0
003100b3 00001028 00000007 00000008 01 0000000f 0000102c 0 0
403100b3 0000102c 00000007 00000008 01 ffffffff 00001030 0 0
407352b3 00001030 f0000000 00000024 05 ff000000 00001034 0 0
007332b3 00001034 ffffffff 00000001 05 00000000 00001038 0 0
00310033 00001038 00000007 00000008 00 00000000 0000103c 0 0
123452b7 0000103c 00000000 00000000 05 12345000 00001040 0 0
00001317 00002000 00000000 00000000 06 00003000 00002004 0 0
00208463 00003000 00000005 00000005 00 00000000 00003008 0 0
00209463 00003004 00000005 00000005 00 00000000 00003008 0 0
fe20cee3 00003010 ffffffff 00000001 00 00000000 0000300c 0 0
0020f463 00003014 00000001 ffffffff 00 00000000 00003018 0 0
00208463 00003020 00000001 00000002 00 00000000 00003028 0 5
010000ef 00004000 00000000 00000000 01 00004004 00004010 0 0
005100e7 00004010 00005000 00000000 01 00004014 00005004 0 0
010000ef 00004100 00000000 00000000 01 00004104 00004104 0 5
00510093 00005000 00000010 00000000 02 00000015 00005004 0 3
00510093 00005004 00000010 00000000 01 00000016 00005008 0 4
00510093 00005008 00000010 00000000 03 00000099 0000500c 0 3
00000073 00006000 00000000 00000000 1f deadbeef 00000000 0 1
003100b3 00006004 00000007 00000008 01 00000000 00000000 1 1
00002083 00006008 00000000 00000000 01 00000000 0000600c 0 2
023100b3 0000600c 00000007 00000008 01 00000038 00006010 0 2
0000000f 00006010 00000000 00000000 00 00000000 00006014 0 2

/* rvfi_check.f */
+incdir+hw
hw/rvfi_check_pkg.sv
hw/retire_if.sv
hw/retire_dispatch.sv
hw/rv32i_spec_lane.sv
hw/verdict_collect.sv
hw/rvfi_check_top.sv
bench/rvfi_check_asserts.sv
bench/rvfi_check_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rvfi_check_tb
FILELIST  ?= rvfi_check.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
